//--- hdl/soc_status_pkg.sv
package soc_status_pkg;

    typedef logic [31:0] word_t;    // pc, ir, display value, odata
    typedef logic [63:0] cycles_t;
    typedef logic [7:0]  seg_t;     // bit 7 dp, bits 6..0 segments a..g
    typedef logic [2:0]  digit_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [11:0] ramp_t;
    typedef logic [12:0] level_t;   // bit 12 direction, 11..0 magnitude
    typedef logic [1:0]  priv_t;

    localparam priv_t PRIV_U = 2'd0;
    localparam priv_t PRIV_S = 2'd1;
    localparam priv_t PRIV_M = 2'd3;

    typedef enum logic [1:0] {
        RUN_IDLE,
        RUN_LOADING,
        RUN_ACTIVE,
        RUN_STOPPED
    } run_state_t;

    typedef struct packed {
        logic  halt;
        logic  finish;
        logic  init_start;
        logic  init_done;
        word_t odata;
    } status_in_t;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic center;
    } btn_t;

    localparam word_t RUN_TIMEOUT = 32'd1000;   // odata above this ends the run

    // letter codes for the banners
    localparam seg_t SEG_BLANK = 8'b0000_0000;
    localparam seg_t SEG_DP    = 8'b1000_0000;
    localparam seg_t SEG_A_UP  = 8'b0111_0111;
    localparam seg_t SEG_R     = 8'b0000_0101;
    localparam seg_t SEG_C     = 8'b0000_1101;
    localparam seg_t SEG_H     = 8'b0001_0111;
    localparam seg_t SEG_P     = 8'b0110_0111;
    localparam seg_t SEG_O     = 8'b0001_1101;
    localparam seg_t SEG_L     = 8'b0000_1110;
    localparam seg_t SEG_A_LO  = 8'b0111_1101;
    localparam seg_t SEG_D     = 8'b0011_1101;
    localparam seg_t SEG_I     = 8'b0001_0000;
    localparam seg_t SEG_N     = 8'b0001_0101;
    localparam seg_t SEG_G     = 8'b1111_1011;   // g carries the dp, as on the board

    localparam seg_t HEX_SEG [0:15] = '{
        8'b0111_1110, 8'b0011_0000, 8'b0110_1101, 8'b0111_1001,
        8'b0011_0011, 8'b0101_1011, 8'b0101_1111, 8'b0111_0000,
        8'b0111_1111, 8'b0111_1011, 8'b0111_0111, 8'b0001_1111,
        8'b0100_1110, 8'b0011_1101, 8'b0100_1111, 8'b0100_0111
    };

    // digit 0 first
    localparam seg_t IDLE_TEXT [0:7] = '{
        SEG_C, SEG_O, SEG_R, SEG_P, SEG_H, SEG_C, SEG_R, SEG_A_UP
    };

    localparam seg_t LOAD_TEXT [0:15] = '{
        SEG_BLANK, SEG_BLANK, SEG_BLANK, SEG_BLANK, SEG_BLANK, SEG_BLANK, SEG_BLANK,
        SEG_L, SEG_O, SEG_A_LO, SEG_D, SEG_I, SEG_N, SEG_G,
        SEG_DP, SEG_DP
    };

    localparam int NUM_RGB = 3;

    // indexed by rgb bit, listed blue, green, red
    localparam level_t RGB_START [NUM_RGB-1:0] = '{13'd0, 13'd64, 13'd512};
    localparam level_t RGB_STEP  [NUM_RGB-1:0] = '{13'd2, 13'd3, 13'd5};

endpackage

//--- hdl/run_monitor.sv
`timescale 1ns/1ps

module run_monitor import soc_status_pkg::*; (
    input  logic       CORE_CLK,
    input  logic       CORE_RST_X,
    input  status_in_t status,
    input  logic       stop_btn,
    output run_state_t run_state,
    output cycles_t    run_cycles
);

    run_state_t state_nxt;
    logic       stop_cond;

    assign stop_cond = stop_btn | status.halt | status.finish | (status.odata > RUN_TIMEOUT);

    always_comb begin
        state_nxt = run_state;
        if (stop_cond) begin
            state_nxt = RUN_STOPPED;    // held until reset
        end else begin
            case (run_state)
                RUN_IDLE: begin
                    if (status.init_done) state_nxt = RUN_ACTIVE;
                    else if (status.init_start) state_nxt = RUN_LOADING;
                end
                RUN_LOADING: begin
                    if (status.init_done) state_nxt = RUN_ACTIVE;
                end
                default: state_nxt = run_state;
            endcase
        end
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            run_state  <= RUN_IDLE;
            run_cycles <= '0;
        end else begin
            run_state <= state_nxt;
            if (run_state == RUN_ACTIVE && !stop_cond) begin
                run_cycles <= run_cycles + 64'd1;
            end
        end
    end

    // once stopped the count is final
    a_stop_freezes_count: assert property (@(posedge CORE_CLK) disable iff (!CORE_RST_X)
        run_state == RUN_STOPPED |=> $stable(run_cycles));

endmodule

//--- hdl/display_select.sv
`timescale 1ns/1ps

module display_select import soc_status_pkg::*; (
    input  logic       CORE_CLK,
    input  logic       CORE_RST_X,
    input  btn_t       btn,
    input  word_t      core_pc,
    input  word_t      core_ir,
    input  logic       kbd_we,
    input  logic [7:0] kbd_data,
    input  logic       mouse_we,
    input  logic [7:0] mouse_data,
    output word_t      disp_value
);

    word_t hist;    // mouse codes in the upper half, keyboard in the lower

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            hist <= '0;
        end else begin
            if (kbd_we) begin
                hist[7:0]  <= kbd_data;
                hist[15:8] <= hist[7:0];        // previous key code
            end
            if (mouse_we) begin
                hist[23:16] <= mouse_data;
                hist[31:24] <= hist[23:16];     // previous mouse code
            end
        end
    end

    always_ff @(posedge CORE_CLK) begin
        if (btn.up || btn.down || btn.center) begin
            disp_value <= '0;
        end else if (btn.left) begin
            disp_value <= core_pc;
        end else if (btn.right) begin
            disp_value <= core_ir;
        end else begin
            disp_value <= hist;
        end
    end

endmodule

//--- hdl/seg_scan.sv
`timescale 1ns/1ps

module seg_scan import soc_status_pkg::*; #(
    parameter int SCAN_DIV = 16000,
    parameter int LOAD_DIV = 2**25
) (
    input  logic       CORE_CLK,
    input  logic       CORE_RST_X,
    input  run_state_t run_state,
    input  word_t      disp_value,
    output logic [7:0] an,          // active low, one digit at a time
    output seg_t       sg           // active low
);

    localparam int SCAN_W = $clog2(SCAN_DIV + 1);
    localparam int LOAD_W = $clog2(LOAD_DIV + 1);

    logic [SCAN_W-1:0] scan_cnt;
    digit_t            digit;       // digit of the current slot
    logic [LOAD_W-1:0] load_cnt;
    logic [3:0]        scroll;      // banner offset, wraps at 16
    logic [3:0]        load_idx;
    nibble_t           nib;
    seg_t              code;
    seg_t              code_q;
    digit_t            slot_q;

    // slot timer
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            scan_cnt <= '0;
            digit    <= '0;
        end else if (scan_cnt == SCAN_W'(SCAN_DIV - 1)) begin
            scan_cnt <= '0;
            digit    <= digit + 3'd1;
        end else begin
            scan_cnt <= scan_cnt + SCAN_W'(1);
        end
    end

    // loading banner scroll, restarts from 0 outside loading
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            load_cnt <= '0;
            scroll   <= '0;
        end else if (run_state != RUN_LOADING) begin
            load_cnt <= '0;
            scroll   <= '0;
        end else if (load_cnt == LOAD_W'(LOAD_DIV - 1)) begin
            load_cnt <= '0;
            scroll   <= scroll + 4'd1;
        end else begin
            load_cnt <= load_cnt + LOAD_W'(1);
        end
    end

    assign load_idx = scroll + 4'd7 - {1'b0, digit};   // modulo 16
    assign nib      = disp_value[{digit, 2'b00} +: 4];

    always_comb begin
        case (run_state)
            RUN_IDLE:    code = IDLE_TEXT[digit];
            RUN_LOADING: code = LOAD_TEXT[load_idx];
            default:     code = HEX_SEG[nib];
        endcase
    end

    // content stage
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            code_q <= '0;
            slot_q <= '0;
        end else begin
            code_q <= code;
            slot_q <= digit;
        end
    end

    // pad stage, both outputs switch together
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            an <= '1;
            sg <= '1;
        end else begin
            an <= ~(8'd1 << slot_q);
            sg <= ~code_q;
        end
    end

    // after the first slot exactly one anode stays driven
    a_one_anode: assert property (@(posedge CORE_CLK) disable iff (!CORE_RST_X)
        an != 8'hff |=> $onehot(~an));

endmodule

//--- hdl/pwm_ramp.sv
`timescale 1ns/1ps

module pwm_ramp import soc_status_pkg::*; (
    input  logic  CORE_CLK,
    input  logic  CORE_RST_X,
    output ramp_t ramp,         // shared by all colour channels
    output logic  ramp_wrap     // last count of the period
);

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            ramp <= '0;
        end else begin
            ramp <= ramp + 12'd1;   // 4095 rolls over to 0
        end
    end

    assign ramp_wrap = &ramp;

endmodule

//--- hdl/breathing_channel.sv
`timescale 1ns/1ps

module breathing_channel import soc_status_pkg::*; #(
    parameter level_t START = 13'd0,
    parameter level_t STEP  = 13'd1
) (
    input  logic  CORE_CLK,
    input  logic  CORE_RST_X,
    input  ramp_t ramp,
    input  logic  ramp_wrap,
    output logic  pwm
);

    level_t level;
    logic   duty_on;

    // direction bit flips the compare so brightness rises then falls
    assign duty_on = level[12] ? (level[11:0] < ramp) : (level[11:0] >= ramp);

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            level <= START;
            pwm   <= 1'b0;
        end else begin
            if (ramp_wrap) begin
                level <= level + STEP;  // once per ramp period, wraps at 8192
            end
            pwm <= duty_on;
        end
    end

endmodule

//--- hdl/status_led_mux.sv
`timescale 1ns/1ps

module status_led_mux import soc_status_pkg::*; (
    input  logic               CORE_CLK,
    input  logic               CORE_RST_X,
    input  logic               breathe,
    input  run_state_t         run_state,
    input  priv_t              priv,
    input  logic [NUM_RGB-1:0] pwm,
    output logic [NUM_RGB-1:0] rgb     // bit 2 blue, bit 1 green, bit 0 red
);

    logic [3:0]         blink_cnt;
    logic [NUM_RGB-1:0] priv_colour;

    always_comb begin
        case (priv)
            PRIV_U:  priv_colour = 3'b001;
            PRIV_S:  priv_colour = 3'b010;
            PRIV_M:  priv_colour = 3'b100;
            default: priv_colour = 3'b000;  // unused code stays dark
        endcase
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            blink_cnt <= '0;
            rgb       <= '0;
        end else begin
            blink_cnt <= blink_cnt + 4'd1;
            if (breathe) begin
                rgb <= pwm;
            end else if (run_state == RUN_IDLE || run_state == RUN_LOADING) begin
                rgb <= '0;                  // no core yet
            end else if (blink_cnt != 4'd0) begin
                rgb <= '0;
            end else begin
                rgb <= priv_colour;         // short flash, 1 of 16 cycles
            end
        end
    end

    a_single_colour: assert property (@(posedge CORE_CLK) disable iff (!CORE_RST_X)
        !breathe |=> $countones(rgb) <= 1);

endmodule

//--- hdl/soc_status_top.sv
`timescale 1ns/1ps

module soc_status_top import soc_status_pkg::*; #(
    parameter int SCAN_DIV = 16000,     // cycles per digit slot
    parameter int LOAD_DIV = 2**25      // cycles per banner scroll step
) (
    input  logic               CORE_CLK,
    input  logic               CORE_RST_X,
    input  status_in_t         status,
    input  btn_t               btn,
    input  word_t              core_pc,
    input  word_t              core_ir,
    input  priv_t              priv,
    input  logic               kbd_we,
    input  logic [7:0]         kbd_data,
    input  logic               mouse_we,
    input  logic [7:0]         mouse_data,
    input  logic               breathe,
    output logic [7:0]         an,
    output seg_t               sg,
    output logic [NUM_RGB-1:0] rgb,
    output cycles_t            run_cycles
);

    run_state_t         run_state;
    word_t              disp_value;
    ramp_t              ramp;
    logic               ramp_wrap;
    logic [NUM_RGB-1:0] pwm;            // one breathing bit per colour

    run_monitor run_monitor_i (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .status     (status),
        .stop_btn   (btn.center),     // center button stops the run
        .run_state  (run_state),
        .run_cycles (run_cycles)
    );

    display_select display_select_i (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .btn        (btn),
        .core_pc    (core_pc),
        .core_ir    (core_ir),
        .kbd_we     (kbd_we),
        .kbd_data   (kbd_data),
        .mouse_we   (mouse_we),
        .mouse_data (mouse_data),
        .disp_value (disp_value)
    );

    seg_scan #(
        .SCAN_DIV (SCAN_DIV),
        .LOAD_DIV (LOAD_DIV)
    ) seg_scan_i (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .run_state  (run_state),
        .disp_value (disp_value),
        .an         (an),
        .sg         (sg)
    );

    pwm_ramp pwm_ramp_i (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .ramp       (ramp),
        .ramp_wrap  (ramp_wrap)
    );

    for (genvar i = 0; i < NUM_RGB; i++) begin : g_rgb
        breathing_channel #(
            .START (RGB_START[i]),
            .STEP  (RGB_STEP[i])
        ) channel_i (
            .CORE_CLK   (CORE_CLK),
            .CORE_RST_X (CORE_RST_X),
            .ramp       (ramp),
            .ramp_wrap  (ramp_wrap),
            .pwm        (pwm[i])
        );
    end

    status_led_mux status_led_mux_i (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .breathe    (breathe),
        .run_state  (run_state),
        .priv       (priv),
        .pwm        (pwm),
        .rgb        (rgb)
    );

endmodule

//--- dv/tb_soc_status.sv
`timescale 1ns/1ps

module tb_soc_status import soc_status_pkg::*; ();

    localparam int SCAN_DIV = 16;
    localparam int LOAD_DIV = 64;
    // rgb bit 0 red, bit 1 green, bit 2 blue
    localparam int CH_START [3] = '{512, 64, 0};
    localparam int CH_STEP  [3] = '{5, 3, 2};

    logic               CORE_CLK;
    logic               CORE_RST_X;
    status_in_t         status;
    btn_t               btn;
    word_t              core_pc;
    word_t              core_ir;
    priv_t              priv;
    logic               kbd_we;
    logic [7:0]         kbd_data;
    logic               mouse_we;
    logic [7:0]         mouse_data;
    logic               breathe;
    logic [7:0]         an;
    seg_t               sg;
    logic [NUM_RGB-1:0] rgb;
    cycles_t            run_cycles;
    int                 cyc = 0;    // rising edges since start

    soc_status_top #(
        .SCAN_DIV (SCAN_DIV),
        .LOAD_DIV (LOAD_DIV)
    ) dut_i (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .status     (status),
        .btn        (btn),
        .core_pc    (core_pc),
        .core_ir    (core_ir),
        .priv       (priv),
        .kbd_we     (kbd_we),
        .kbd_data   (kbd_data),
        .mouse_we   (mouse_we),
        .mouse_data (mouse_data),
        .breathe    (breathe),
        .an         (an),
        .sg         (sg),
        .rgb        (rgb),
        .run_cycles (run_cycles)
    );

    initial begin
        CORE_CLK = 1'b0;
        forever #5 CORE_CLK = ~CORE_CLK;
    end

    always @(posedge CORE_CLK) cyc <= cyc + 1;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp));
        end
    endtask

    task automatic apply_reset();
        @(posedge CORE_CLK);
        CORE_RST_X <= 1'b0;
        status     <= '0;
        btn        <= '0;
        priv       <= PRIV_U;
        kbd_we     <= 1'b0;
        mouse_we   <= 1'b0;
        breathe    <= 1'b0;
        repeat (5) @(posedge CORE_CLK);
        CORE_RST_X <= 1'b1;
    endtask

    // entered on a falling edge and left two cycles after the anodes move
    task automatic next_slot(output int d);
        logic [7:0] prev;
        int         n;
        int         b;
        prev = an;
        n = 0;
        while (an == prev) begin
            if (n == 4 * SCAN_DIV) fail_run("timeout: the anodes never moved to the next digit");
            @(negedge CORE_CLK);
            n++;
        end
        repeat (2) @(negedge CORE_CLK);
        check_eq("zero bits of an", 64'($countones(~an)), 64'd1);
        d = 0;
        for (b = 7; b >= 0; b--) begin
            if (!an[b]) d = b;
        end
    endtask

    task automatic send_code(input bit is_mouse, input logic [7:0] code);
        @(posedge CORE_CLK);
        kbd_we     <= !is_mouse;
        mouse_we   <= is_mouse;
        kbd_data   <= code;
        mouse_data <= code;
        @(posedge CORE_CLK);
        kbd_we     <= 1'b0;
        mouse_we   <= 1'b0;
    endtask

    task automatic check_digits(input word_t value, input string what);
        int   d;
        seg_t exp_sg;
        @(negedge CORE_CLK);
        repeat (8) begin
            next_slot(d);
            exp_sg = ~HEX_SEG[value[4*d +: 4]];
            check_eq({what, " sg"}, 64'(sg), 64'(exp_sg));
        end
    endtask

    function automatic int duty_count(input level_t lvl);
        // direction set means high above the magnitude and otherwise at or below it
        if (lvl[12]) return 4095 - int'(lvl[11:0]);
        return int'(lvl[11:0]) + 1;
    endfunction

    task automatic test_idle_banner();
        int   d;
        int   i;
        seg_t exp_sg;
        apply_reset();
        @(negedge CORE_CLK);
        check_eq("an after reset", 64'(an), 64'hff);
        check_eq("sg after reset", 64'(sg), 64'hff);
        check_eq("rgb after reset", 64'(rgb), 64'd0);
        check_eq("run_cycles after reset", run_cycles, 64'd0);
        for (i = 0; i < 8; i++) begin
            next_slot(d);
            check_eq("digit order", 64'(d), 64'(i));
            exp_sg = ~IDLE_TEXT[d];
            check_eq("idle sg", 64'(sg), 64'(exp_sg));
        end
    endtask

    task automatic test_loading_banner();
        int   d;
        int   e;
        int   entry;
        int   idx;
        seg_t exp_sg;
        apply_reset();
        status.init_start <= 1'b1;
        @(posedge CORE_CLK);
        status.init_start <= 1'b0;  // loading from this edge on
        @(negedge CORE_CLK);
        entry = cyc;
        repeat (2) @(negedge CORE_CLK);
        check_eq("first loading an", 64'(an), 64'hfe);
        exp_sg = ~LOAD_TEXT[7];     // digit 0 starts on L
        check_eq("first loading sg", 64'(sg), 64'(exp_sg));
        repeat (12) begin
            next_slot(d);
            e = cyc - entry;
            if (e % LOAD_DIV >= 2) begin    // skip slots right at a scroll step
                idx = (e / LOAD_DIV + 7 - d) & 15;
                exp_sg = ~LOAD_TEXT[idx];
                check_eq("loading sg", 64'(sg), 64'(exp_sg));
            end
        end
    endtask

    task automatic test_value_display();
        logic [7:0] k1;
        logic [7:0] k2;
        logic [7:0] m1;
        logic [7:0] m2;
        k1 = 8'($urandom);
        k2 = 8'($urandom);
        m1 = 8'($urandom);
        m2 = 8'($urandom);
        apply_reset();
        status.init_done <= 1'b1;
        core_pc <= $urandom;
        core_ir <= $urandom;
        send_code(1'b0, k1);
        send_code(1'b0, k2);
        send_code(1'b1, m1);
        send_code(1'b1, m2);
        repeat (4) @(posedge CORE_CLK);
        check_digits({m1, m2, k1, k2}, "history");  // older code above newer
        @(posedge CORE_CLK);
        btn.left <= 1'b1;
        repeat (4) @(posedge CORE_CLK);
        check_digits(core_pc, "pc");
        @(posedge CORE_CLK);
        btn.left  <= 1'b0;
        btn.right <= 1'b1;
        repeat (4) @(posedge CORE_CLK);
        check_digits(core_ir, "ir");
        @(posedge CORE_CLK);
        btn.right  <= 1'b0;
        btn.center <= 1'b1;
        repeat (4) @(posedge CORE_CLK);
        check_digits('0, "blank");
    endtask

    // n counted edges in the active state and then a stop by halt or odata
    task automatic count_run(input int n, input bit by_odata);
        apply_reset();
        status.init_done <= 1'b1;
        status.odata     <= by_odata ? RUN_TIMEOUT : '0;   // limit itself keeps running
        @(posedge CORE_CLK);        // active from here, not yet counted
        repeat (n) @(posedge CORE_CLK);
        if (by_odata) status.odata <= RUN_TIMEOUT + 1;
        else status.halt <= 1'b1;
        @(negedge CORE_CLK);
        check_eq("run_cycles at stop", run_cycles, 64'(n));
        repeat (50) @(negedge CORE_CLK);
        check_eq("run_cycles after stop", run_cycles, 64'(n));
    endtask

    task automatic test_breathing();
        int     hi [3];
        int     k;
        int     i;
        level_t lvl;
        apply_reset();
        breathe <= 1'b1;
        repeat (2) @(negedge CORE_CLK);     // ramp to pwm to rgb
        for (k = 0; k < 2; k++) begin
            hi = '{0, 0, 0};
            repeat (4096) begin
                @(negedge CORE_CLK);
                for (i = 0; i < 3; i++) hi[i] += int'(rgb[i]);
            end
            for (i = 0; i < 3; i++) begin
                lvl = level_t'(CH_START[i] + k * CH_STEP[i]);
                check_eq($sformatf("rgb[%0d] high cycles", i), 64'(hi[i]), 64'(duty_count(lvl)));
            end
        end
    endtask

    task automatic test_priv_flash();
        priv_t      codes [4] = '{PRIV_U, PRIV_S, PRIV_M, 2'd2};
        logic [2:0] colour [4] = '{3'b001, 3'b010, 3'b100, 3'b000};
        int         seen;
        int         j;
        apply_reset();
        status.init_done <= 1'b1;
        for (j = 0; j < 4; j++) begin
            priv <= codes[j];
            repeat (4) @(posedge CORE_CLK);
            seen = 0;
            repeat (48) begin
                @(negedge CORE_CLK);
                if (rgb != '0) begin
                    seen++;
                    check_eq("rgb colour", 64'(rgb), 64'(colour[j]));
                end
            end
            check_eq("rgb flashes in 48 cycles", 64'(seen), (j == 3) ? 64'd0 : 64'd3);
            @(posedge CORE_CLK);
        end
    endtask

    initial begin
        void'($urandom(32'he1a5_2d8b));
        CORE_RST_X = 1'b0;
        status     = '0;
        btn        = '0;
        core_pc    = '0;
        core_ir    = '0;
        priv       = PRIV_U;
        kbd_we     = 1'b0;
        kbd_data   = '0;
        mouse_we   = 1'b0;
        mouse_data = '0;
        breathe    = 1'b0;
        test_idle_banner();
        test_loading_banner();
        test_value_display();
        count_run(20 + int'($urandom % 40), 1'b0);
        count_run(20 + int'($urandom % 40), 1'b1);
        test_breathing();
        test_priv_flash();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- tb.f
hdl/soc_status_pkg.sv
hdl/run_monitor.sv
hdl/display_select.sv
hdl/seg_scan.sv
hdl/pwm_ramp.sv
hdl/breathing_channel.sv
hdl/status_led_mux.sv
hdl/soc_status_top.sv
dv/tb_soc_status.sv

//--- Makefile
TOP := tb_soc_status

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
